/* exec_unit.f */
source/exec_pkg.sv
source/alu.sv
source/op_queue.sv
source/muldiv_unit.sv
source/exec_ctrl.sv
source/credit_counter.sv
source/exec_unit.sv
tb/exec_monitor.sv
tb/exec_assertions.sv
tb/tb_exec_unit.sv

/* Bender.yml */
package:
  name: exec_unit

sources:
  - source/exec_pkg.sv
  - source/alu.sv
  - source/op_queue.sv
  - source/muldiv_unit.sv
  - source/exec_ctrl.sv
  - source/credit_counter.sv
  - source/exec_unit.sv
  - target: test
    files:
      - tb/exec_monitor.sv
      - tb/exec_assertions.sv
      - tb/tb_exec_unit.sv

/* tb/exec_testdata.txt */
// Columns: opcode a b expected_result expected_flags
// Flags are {zero, negative, borrow}
00 F0F0F0F0 0FF00FF0 00F000F0 0
01 12340000 00005678 12345678 0
02 7FFFFFFF 00000001 80000000 2
03 A5A5A5A5 A5A5A5A5 00000000 4
04 00000005 00000007 FFFFFFFE 2
05 00000000 00000000 FFFFFFFF 2
06 00000001 00000024 00000010 0
07 80000000 0000001F 00000001 0
08 80000000 00000004 F8000000 2
08 80000010 00000021 C0000008 2
09 FFFFFFFF 00000001 00000001 0
0A FFFFFFFF 00000001 00000000 4
13 00000003 00000005 FFFFFFFE 3
13 00000009 00000004 00000005 0
0B FFFFFFFD 00000007 FFFFFFEB 2
0C FFFFFFFD 00000007 FFFFFFFF 2
0D FFFFFFFF FFFFFFFF FFFFFFFF 2
0E FFFFFFFF FFFFFFFF FFFFFFFE 2
0C 80000000 80000000 40000000 0
0F FFFFFFEC 00000003 FFFFFFFA 2
11 FFFFFFEC 00000003 FFFFFFFE 2
10 00000064 00000007 0000000E 0
12 00000064 00000007 00000002 0
0F 00000005 00000000 FFFFFFFF 2
11 00000005 00000000 00000005 0
0F 80000000 FFFFFFFF 80000000 2
11 80000000 FFFFFFFF 00000000 4
10 12345678 00000000 FFFFFFFF 2
02 00000003 00000004 00000007 0
0B 00000000 12345678 00000000 4

/* tb/tb_exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_unit
  import exec_pkg::*;
();

  localparam int NUM_TESTS  = 30;
  localparam int WAIT_LIMIT = 2000;                          // Cycles per wait loop

  logic        clk;
  logic        reset;
  logic        req_valid;
  exec_req_t   req;
  logic        resp_credit;
  logic        in_credit;
  logic        resp_valid;
  exec_resp_t  resp;

  logic [31:0] vec [NUM_TESTS*5];                            // Five words per test
  int          sent_count;
  int          credits_back;
  int          resp_seen;
  int          credits_returned;
  int          tb_errors;
  int          lcg_state;
  logic        withhold;
  logic        send_stuck;

  int          done_count;
  int          pass_count;
  int          fail_count;
  int          proto_errors;
  int          up_model;

  exec_unit uut (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .in_credit   (in_credit),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_credit (resp_credit)
  );

  exec_monitor u_monitor (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (req_valid),
    .req          (req),
    .in_credit    (in_credit),
    .resp_valid   (resp_valid),
    .resp         (resp),
    .resp_credit  (resp_credit),
    .done_count   (done_count),
    .pass_count   (pass_count),
    .fail_count   (fail_count),
    .proto_errors (proto_errors),
    .up_model     (up_model)
  );

  function automatic int next_rand(input int range);
    lcg_state = lcg_state * 1103515245 + 12345;
    return ((lcg_state >>> 16) & 32'h7fff) % range;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                                   // 8 ns period
  end

  always @(posedge clk)
  begin
    if (reset)
    begin
      credits_back <= 0;
      resp_seen    <= 0;
    end
    else
    begin
      if (in_credit)
        credits_back <= credits_back + 1;
      if (resp_valid)
        resp_seen <= resp_seen + 1;                          // Each response owes a credit
    end
  end

  task automatic send_test(input int i);
    int waited;
    waited = 0;
    while ((QUEUE_DEPTH - sent_count + credits_back) <= 0 && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited >= WAIT_LIMIT)
    begin
      $display("Timeout waiting for an upstream credit before test %0d", i);
      tb_errors++;
      send_stuck = 1'b1;
    end
    else
    begin
      req_valid = 1'b1;
      req.op    = alu_op_e'(vec[5*i][4:0]);
      req.a     = vec[5*i+1];
      req.b     = vec[5*i+2];
      req.tag   = TAG_W'(i % 16);
      sent_count++;
      @(posedge clk);
      #1;
      req_valid = 1'b0;
    end
  endtask

  // Returns one downstream credit per response after a random delay
  initial
  begin : credit_return
    int  waited;
    bit  running;
    running = 1'b1;
    waited  = 0;
    while (reset !== 1'b0 && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    while (running)
    begin
      waited = 0;
      while ((resp_seen == credits_returned || withhold) && waited < WAIT_LIMIT)
      begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (waited >= WAIT_LIMIT)
        running = 1'b0;                                      // Traffic is over
      else
      begin
        repeat (next_rand(4))
        begin
          @(posedge clk);
          #1;
        end
        resp_credit = 1'b1;
        @(posedge clk);
        #1;
        resp_credit = 1'b0;
        credits_returned++;
      end
    end
  end

  // Withholds downstream credits for a while from the eighth request on
  initial
  begin : withhold_window
    int waited;
    withhold = 1'b0;
    waited   = 0;
    while ((reset !== 1'b0 || sent_count < 8) && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    withhold = 1'b1;
    repeat (60) @(posedge clk);
    #1;
    withhold = 1'b0;
  end

  initial
  begin : main
    int waited;
    req_valid        = 1'b0;
    req              = '0;
    resp_credit      = 1'b0;
    reset            = 1'b1;
    sent_count       = 0;
    credits_returned = 0;
    tb_errors        = 0;
    send_stuck       = 1'b0;
    lcg_state        = 76668;
    $readmemh("tb/exec_testdata.txt", vec);
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < NUM_TESTS && !send_stuck; i++)
    begin
      repeat (next_rand(3))
      begin
        @(posedge clk);
        #1;
      end
      send_test(i);
    end

    waited = 0;
    while (done_count < sent_count && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited >= WAIT_LIMIT)
    begin
      $display("Timeout: only %0d of %0d responses arrived", done_count, sent_count);
      tb_errors++;
    end

    waited = 0;
    while (up_model != QUEUE_DEPTH && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited >= WAIT_LIMIT)
    begin
      $display("Upstream credits ended at %0d instead of %0d", up_model, QUEUE_DEPTH);
      tb_errors++;
    end

    repeat (5) @(posedge clk);
    $display("%0d run, %0d passed, %0d failed, %0d protocol, %0d assertion, %0d other errors",
             done_count, pass_count, fail_count, proto_errors,
             uut.u_assertions.assert_fails, tb_errors);
    if (fail_count == 0 && proto_errors == 0 && tb_errors == 0 &&
        uut.u_assertions.assert_fails == 0 && done_count == NUM_TESTS)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/exec_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_assertions
  import exec_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  input wire logic req_valid,
  input wire logic pop,
  input wire logic resp_valid,
  input wire logic resp_credit
);

  int occ;                                                   // Queue fill level
  int open_reqs;                                             // Requests not yet answered
  int dn;                                                    // Downstream credits left
  int assert_fails = 0;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      occ       <= 0;
      open_reqs <= 0;
      dn        <= RESP_CREDITS;
    end
    else
    begin
      occ       <= occ + int'(req_valid) - int'(pop);
      open_reqs <= open_reqs + int'(req_valid) - int'(resp_valid);
      dn        <= dn - int'(resp_valid) + int'(resp_credit);
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> occ < QUEUE_DEPTH)
  else
  begin
    $error("Request pushed into a full queue");
    assert_fails++;
  end

  a_pop_needs_entry: assert property (@(posedge clk) disable iff (reset)
    pop |-> occ > 0)
  else
  begin
    $error("Queue popped while it held no request");
    assert_fails++;
  end

  a_resp_needs_request: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> open_reqs > 0)
  else
  begin
    $error("Response sent with no request outstanding");
    assert_fails++;
  end

  a_resp_has_credit: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> dn > 0)
  else
  begin
    $error("Response sent beyond the downstream credits");
    assert_fails++;
  end

endmodule

bind exec_unit exec_assertions u_assertions (
  .clk         (clk),
  .reset       (reset),
  .req_valid   (req_valid),
  .pop         (pop),
  .resp_valid  (resp_valid),
  .resp_credit (resp_credit)
);

`default_nettype wire

/* tb/exec_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_monitor
  import exec_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       req_valid,
  input  wire exec_req_t  req,
  input  wire logic       in_credit,
  input  wire logic       resp_valid,
  input  wire exec_resp_t resp,
  input  wire logic       resp_credit,
  output int              done_count,
  output int              pass_count,
  output int              fail_count,
  output int              proto_errors,
  output int              up_model
);

  localparam int NUM_TESTS = 30;

  logic [31:0] vec [NUM_TESTS*5];
  int          pending [$];                                  // Test indices in request order
  int          req_count;
  int          dn_model;                                     // Downstream credits the DUT holds

  initial
    $readmemh("tb/exec_testdata.txt", vec);

  task automatic check_response();
    int                idx;
    alu_op_e           op_v;
    logic [DATA_W-1:0] exp_result;
    exec_flags_t       exp_flags;
    logic [TAG_W-1:0]  exp_tag;
    string             name;
    if (pending.size() == 0)
    begin
      $display("Response with tag %h arrived with no request outstanding", resp.tag);
      proto_errors++;
    end
    else
    begin
      idx        = pending.pop_front();
      op_v       = alu_op_e'(vec[5*idx][4:0]);
      exp_result = vec[5*idx+3];
      exp_flags  = vec[5*idx+4][2:0];
      exp_tag    = TAG_W'(idx % 16);                         // Order shows in the tag
      name       = $sformatf("test%0d_%s", idx, op_v.name());
      if (resp.result !== exp_result || resp.flags !== exp_flags || resp.tag !== exp_tag)
      begin
        $display("ERR %s expected result=%h flags=%b tag=%h actual result=%h flags=%b tag=%h",
                 name, exp_result, exp_flags, exp_tag, resp.result, resp.flags, resp.tag);
        fail_count++;
      end
      else
      begin
        $display("ok  %s result=%h flags=%b tag=%h", name, resp.result, resp.flags, resp.tag);
        pass_count++;
      end
      done_count++;
    end
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      done_count   = 0;
      pass_count   = 0;
      fail_count   = 0;
      proto_errors = 0;
      req_count    = 0;
      up_model     = QUEUE_DEPTH;
      dn_model     = RESP_CREDITS;
      pending.delete();
    end
    else
    begin
      if (req_valid)
      begin
        if (up_model <= 0)
        begin
          $display("Request for test %0d sent while upstream held no credit", req_count);
          proto_errors++;
        end
        pending.push_back(req_count);
        req_count++;
      end
      up_model = up_model - int'(req_valid) + int'(in_credit);
      if (up_model > QUEUE_DEPTH)
      begin
        $display("The DUT returned more input credits than requests it took");
        proto_errors++;
      end
      if (resp_valid && dn_model <= 0)
      begin
        $display("Response sent at %0t while the DUT held no downstream credit", $time);
        proto_errors++;
      end
      dn_model = dn_model - int'(resp_valid) + int'(resp_credit);
      if (resp_valid)
        check_response();
    end
  end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit
  import exec_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       req_valid,
  input  wire exec_req_t  req,
  output logic            in_credit,
  output logic            resp_valid,
  output exec_resp_t      resp,
  input  wire logic       resp_credit
);

  exec_req_t         head;
  logic              not_empty;
  logic              pop;
  logic [DATA_W-1:0] alu_result;
  logic              alu_borrow;
  logic              is_muldiv;
  logic              md_start;
  logic              md_done;
  logic [DATA_W-1:0] md_result;
  logic              has_credit;
  logic              credit_use;

  op_queue u_queue (
    .clk       (clk),
    .reset     (reset),
    .push      (req_valid),
    .push_req  (req),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .in_credit (in_credit)
  );

  // Both datapaths look at the queue head; muldiv latches it on start
  alu u_alu (
    .op        (head.op),
    .a         (head.a),
    .b         (head.b),
    .result    (alu_result),
    .borrow    (alu_borrow),
    .is_muldiv (is_muldiv)
  );

  muldiv_unit u_muldiv (
    .clk    (clk),
    .reset  (reset),
    .start  (md_start),
    .op     (head.op),
    .a      (head.a),
    .b      (head.b),
    .done   (md_done),
    .result (md_result)
  );

  exec_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .head       (head),
    .not_empty  (not_empty),
    .alu_result (alu_result),
    .alu_borrow (alu_borrow),
    .is_muldiv  (is_muldiv),
    .md_start   (md_start),
    .md_done    (md_done),
    .md_result  (md_result),
    .pop        (pop),
    .has_credit (has_credit),
    .credit_use (credit_use),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  credit_counter u_credits (
    .clk        (clk),
    .reset      (reset),
    .use_credit (credit_use),
    .give       (resp_credit),
    .has_credit (has_credit)
  );

endmodule

`default_nettype wire

/* source/credit_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module credit_counter
  import exec_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic use_credit,
  input  wire logic give,
  output logic      has_credit
);

  logic [CREDIT_W-1:0] count_q;                              // Downstream credits held

  always_ff @(posedge clk)
  begin
    if (reset)
      count_q <= CREDIT_W'(RESP_CREDITS);
    else if (use_credit && !give)
      count_q <= count_q - 1'b1;
    else if (give && !use_credit)
      count_q <= count_q + 1'b1;
  end

  assign has_credit = (count_q != '0);

endmodule

`default_nettype wire

/* source/exec_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_ctrl
  import exec_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire exec_req_t         head,
  input  wire logic              not_empty,
  input  wire logic [DATA_W-1:0] alu_result,
  input  wire logic              alu_borrow,
  input  wire logic              is_muldiv,
  output logic                   md_start,
  input  wire logic              md_done,
  input  wire logic [DATA_W-1:0] md_result,
  output logic                   pop,
  input  wire logic              has_credit,
  output logic                   credit_use,
  output logic                   resp_valid,
  output exec_resp_t             resp
);

  ctrl_state_e        state_q;
  ctrl_state_e        state_d;
  logic               load;
  logic [DATA_W-1:0]  load_result;
  exec_resp_t         resp_q;

  always_comb
  begin
    state_d    = state_q;
    md_start   = 1'b0;
    pop        = 1'b0;
    load       = 1'b0;
    credit_use = 1'b0;
    case (state_q)
      st_idle:
      begin
        if (not_empty && is_muldiv)
        begin
          md_start = 1'b1;                                   // Head stays queued until done
          state_d  = st_md_run;
        end
        else if (not_empty)
        begin
          pop        = 1'b1;
          load       = 1'b1;
          credit_use = has_credit;
          state_d    = has_credit ? st_idle : st_hold;
        end
      end
      st_md_run:
      begin
        if (md_done)
        begin
          pop        = 1'b1;
          load       = 1'b1;
          credit_use = has_credit;
          state_d    = has_credit ? st_idle : st_hold;
        end
      end
      st_hold:
      begin
        if (has_credit)
        begin
          credit_use = 1'b1;                                 // Release the parked response
          state_d    = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  assign load_result = (state_q == st_md_run) ? md_result : alu_result;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q    <= st_idle;
      resp_valid <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      resp_valid <= credit_use;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      resp_q.result         <= load_result;
      resp_q.flags.zero     <= (load_result == '0);
      resp_q.flags.negative <= load_result[DATA_W-1];
      resp_q.flags.borrow   <= (state_q == st_md_run) ? 1'b0 : alu_borrow;
      resp_q.tag            <= head.tag;
    end
  end

  assign resp = resp_q;

endmodule

`default_nettype wire

/* source/muldiv_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit
  import exec_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              start,
  input  wire alu_op_e           op,
  input  wire logic [DATA_W-1:0] a,
  input  wire logic [DATA_W-1:0] b,
  output logic                   done,
  output logic [DATA_W-1:0]      result
);

  localparam logic [DATA_W-1:0] MIN_NEG = {1'b1, {(DATA_W-1){1'b0}}};

  function automatic logic is_div_op(alu_op_e o);
    return o inside {op_div, op_divu, op_rem, op_remu};
  endfunction

  logic                  busy;
  logic [MD_CNT_W-1:0]   cnt;
  alu_op_e               op_q;
  logic [DATA_W-1:0]     a_q;                                // Original dividend for special cases
  logic [DATA_W-1:0]     opd;                                // Multiplicand or divisor magnitude
  logic [2*DATA_W-1:0]   prod;                               // {acc, multiplier} or {rem, quot}
  logic [2*DATA_W-1:0]   prod_next;
  logic                  neg_q;
  logic                  div0_q;
  logic                  ovf_q;
  logic                  a_neg;
  logic                  b_neg;
  logic [DATA_W-1:0]     abs_a;
  logic [DATA_W-1:0]     abs_b;
  logic [DATA_W:0]       mul_sum;
  logic [DATA_W:0]       div_diff;
  logic [2*DATA_W-1:0]   prod_fix;
  logic [DATA_W-1:0]     quo_fix;
  logic [DATA_W-1:0]     rem_fix;

  // Signedness of each operand follows the opcode
  assign a_neg = a[DATA_W-1] & (op inside {op_mulh, op_mulhsu, op_div, op_rem});
  assign b_neg = b[DATA_W-1] & (op inside {op_mulh, op_div, op_rem});
  assign abs_a = a_neg ? -a : a;
  assign abs_b = b_neg ? -b : b;

  assign mul_sum  = {1'b0, prod[2*DATA_W-1:DATA_W]} + (prod[0] ? {1'b0, opd} : '0);
  assign div_diff = prod[2*DATA_W-1:DATA_W-1] - {1'b0, opd};

  always_comb
  begin
    if (is_div_op(op_q))
    begin
      if (!div_diff[DATA_W])                                 // Trial subtract fits
        prod_next = {div_diff[DATA_W-1:0], prod[DATA_W-2:0], 1'b1};
      else
        prod_next = {prod[2*DATA_W-2:0], 1'b0};
    end
    else
    begin
      prod_next = {mul_sum, prod[DATA_W-1:1]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy <= 1'b1;
        cnt  <= '0;
      end
      else if (busy)
      begin
        cnt <= cnt + 1'b1;
        if (cnt == MD_CNT_W'(MD_STEPS - 1))
        begin
          busy <= 1'b0;
          done <= 1'b1;                                      // Fix-up happens while done is high
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      op_q   <= op;
      a_q    <= a;
      neg_q  <= (op inside {op_rem, op_remu}) ? a_neg : (a_neg ^ b_neg);
      div0_q <= (b == '0);
      ovf_q  <= (op inside {op_div, op_rem}) && (a == MIN_NEG) && (b == '1);
      if (is_div_op(op))
      begin
        prod <= {{DATA_W{1'b0}}, abs_a};
        opd  <= abs_b;
      end
      else
      begin
        prod <= {{DATA_W{1'b0}}, abs_b};
        opd  <= abs_a;
      end
    end
    else if (busy)
    begin
      prod <= prod_next;
    end
  end

  // Sign correction on the final accumulator
  assign prod_fix = neg_q ? -prod : prod;
  assign quo_fix  = neg_q ? -prod[DATA_W-1:0] : prod[DATA_W-1:0];
  assign rem_fix  = neg_q ? -prod[2*DATA_W-1:DATA_W] : prod[2*DATA_W-1:DATA_W];

  always_comb
  begin
    case (op_q)
      op_mul:                       result = prod_fix[DATA_W-1:0];
      op_mulh, op_mulhsu, op_mulhu: result = prod_fix[2*DATA_W-1:DATA_W];
      op_div, op_divu:              result = div0_q ? '1 : (ovf_q ? a_q : quo_fix);
      op_rem, op_remu:              result = div0_q ? a_q : (ovf_q ? '0 : rem_fix);
      default:                      result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/op_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module op_queue
  import exec_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       push,
  input  wire exec_req_t  push_req,
  input  wire logic       pop,
  output exec_req_t       head,
  output logic            not_empty,
  output logic            in_credit
);

  exec_req_t         mem [QUEUE_DEPTH];
  logic [QPTR_W:0]   wr_ptr;                                 // Extra bit tells full from empty
  logic [QPTR_W:0]   rd_ptr;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr[QPTR_W-1:0]] <= push_req;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      in_credit <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      in_credit <= pop;                                      // Freed slot goes back upstream
    end
  end

  assign head      = mem[rd_ptr[QPTR_W-1:0]];
  assign not_empty = (wr_ptr != rd_ptr);

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu
  import exec_pkg::*;
(
  input  wire alu_op_e           op,
  input  wire logic [DATA_W-1:0] a,
  input  wire logic [DATA_W-1:0] b,
  output logic [DATA_W-1:0]      result,
  output logic                   borrow,
  output logic                   is_muldiv
);

  logic [DATA_W:0]   diff_u;                                 // Top bit is the borrow out
  logic [4:0]        shamt;
  logic              lt_s;
  logic              lt_u;

  assign diff_u = {1'b0, a} - {1'b0, b};
  assign shamt  = b[4:0];                                    // Only low five bits count
  assign lt_s   = ($signed(a) < $signed(b));
  assign lt_u   = (a < b);

  always_comb
  begin
    result    = '0;
    borrow    = 1'b0;
    is_muldiv = 1'b0;
    case (op)
      op_and:  result = a & b;
      op_or:   result = a | b;
      op_add:  result = a + b;
      op_xor:  result = a ^ b;
      op_sub:  result = a - b;
      op_not:  result = ~a;
      op_sll:  result = a << shamt;
      op_srl:  result = a >> shamt;
      op_sra:  result = $signed(a) >>> shamt;                // Sign bit fills from the left
      op_slt:  result = {{(DATA_W-1){1'b0}}, lt_s};
      op_sltu: result = {{(DATA_W-1){1'b0}}, lt_u};
      op_subu:
      begin
        result = diff_u[DATA_W-1:0];
        borrow = diff_u[DATA_W];
      end
      op_mul, op_mulh, op_mulhsu, op_mulhu,
      op_div, op_divu, op_rem, op_remu:
      begin
        is_muldiv = 1'b1;                                    // Handled by muldiv_unit
      end
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/exec_pkg.sv */
`default_nettype none

package exec_pkg;

  localparam int DATA_W       = 32;                          // Operand and result width
  localparam int TAG_W        = 4;
  localparam int QUEUE_DEPTH  = 4;                           // Also the upstream credits at reset
  localparam int RESP_CREDITS = 2;                           // Downstream credits at reset
  localparam int MD_STEPS     = 32;                          // Multiply/divide iterations

  localparam int QPTR_W   = $clog2(QUEUE_DEPTH);             // Queue slot index
  localparam int CREDIT_W = $clog2(RESP_CREDITS + 1);        // Holds 0 .. RESP_CREDITS
  localparam int MD_CNT_W = $clog2(MD_STEPS);                // Step counter

  // Opcode values match the encoding used by the issue stage
  typedef enum logic [4:0] {
    op_and    = 5'd0,
    op_or     = 5'd1,
    op_add    = 5'd2,
    op_xor    = 5'd3,
    op_sub    = 5'd4,
    op_not    = 5'd5,
    op_sll    = 5'd6,
    op_srl    = 5'd7,
    op_sra    = 5'd8,
    op_slt    = 5'd9,
    op_sltu   = 5'd10,
    op_mul    = 5'd11,
    op_mulh   = 5'd12,
    op_mulhsu = 5'd13,
    op_mulhu  = 5'd14,
    op_div    = 5'd15,
    op_divu   = 5'd16,
    op_rem    = 5'd17,
    op_remu   = 5'd18,
    op_subu   = 5'd19
  } alu_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_md_run,
    st_hold
  } ctrl_state_e;

  typedef struct packed {
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [TAG_W-1:0]  tag;
  } exec_req_t;                                              // 73 bits

  typedef struct packed {
    logic zero;
    logic negative;
    logic borrow;                                            // Only set by op_subu
  } exec_flags_t;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    exec_flags_t       flags;
    logic [TAG_W-1:0]  tag;
  } exec_resp_t;                                             // 39 bits

endpackage

`default_nettype wire
